// File: Bender.yml
package:
  name: irq_sleep_ctrl

sources:
  - irq_pkg.sv
  - irq_csr_regs.sv
  - irq_arbiter.sv
  - irq_ack_gen.sv
  - wfi_sleep_ctrl.sv
  - irq_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_irq_model.sv
      - tb_irq_top.sv

// File: irq_ack_gen.sv
`default_nettype none

module irq_ack_gen
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                win_valid_i,
  input  logic [IRQ_ID_W-1:0] win_id_i,
  input  logic [NUM_IRQ-1:0]  mip_i,
  input  logic [NUM_IRQ-1:0]  mie_i,
  input  logic                mstatus_mie_i,
  input  priv_lvl_e           priv_lvl_i,
  output logic                irq_ack_o,
  output logic [IRQ_ID_W-1:0] irq_id_o
);

  logic                allowed;
  logic                same_claim;
  logic                ack_d;
  logic                claimed_q;
  logic [IRQ_ID_W-1:0] claimed_id_q;

  // M-mode needs the global enable, U-mode takes any enabled pending line
  assign allowed = ((priv_lvl_i == PRIV_M) && mstatus_mie_i) ||
                   ((priv_lvl_i == PRIV_U) && (|(mip_i & mie_i)));

  assign same_claim = claimed_q && (claimed_id_q == win_id_i);
  assign ack_d      = win_valid_i && allowed && !same_claim && !irq_ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_o    <= 1'b0;
      irq_id_o     <= '0;
      claimed_q    <= 1'b0;
      claimed_id_q <= '0;
    end else begin
      irq_ack_o <= ack_d;
      if (ack_d) begin
        irq_id_o     <= win_id_i;
        claimed_q    <= 1'b1;
        claimed_id_q <= win_id_i;
      end else if (!win_valid_i || (win_id_i != claimed_id_q)) begin
        // Winner moved on so the next one may be acknowledged
        claimed_q <= 1'b0;
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o);

  a_id_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> VALID_IRQ_MASK[irq_id_o]);

endmodule

`default_nettype wire

// File: irq_arbiter.sv
`default_nettype none

module irq_arbiter
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NUM_IRQ-1:0]  irq_i,
  input  logic [NUM_IRQ-1:0]  mie_i,
  output logic [NUM_IRQ-1:0]  mip_o,
  output logic                wake_irq_o,
  output logic                win_valid_o,
  output logic [IRQ_ID_W-1:0] win_id_o
);

  logic [NUM_IRQ-1:0]  pend;
  logic                next_valid;
  logic [IRQ_ID_W-1:0] next_id;

  // ----------------------------------------
  // Stage 1 samples the interrupt lines
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_o <= '0;
    end else begin
      mip_o <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign pend       = mip_o & mie_i;
  assign wake_irq_o = |pend;

  // ----------------------------------------
  // Fixed priority pick
  // ----------------------------------------

  always_comb begin
    next_valid = 1'b0;
    next_id    = '0;
    if (|pend[NUM_IRQ-1:16]) begin
      next_valid = 1'b1;
      // Ascending scan so the highest set line wins
      for (int i = 16; i < NUM_IRQ; i++) begin
        if (pend[i]) begin
          next_id = IRQ_ID_W'(i);
        end
      end
    end else if (pend[11]) begin
      next_valid = 1'b1;
      next_id    = IRQ_ID_W'(11);
    end else if (pend[3]) begin
      next_valid = 1'b1;
      next_id    = IRQ_ID_W'(3);
    end else if (pend[7]) begin
      next_valid = 1'b1;
      next_id    = IRQ_ID_W'(7);
    end
  end

  // ----------------------------------------
  // Stage 2 registers the winner
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_valid_o <= 1'b0;
      win_id_o    <= '0;
    end else begin
      win_valid_o <= next_valid;
      win_id_o    <= next_id;
    end
  end

  a_mip_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~VALID_IRQ_MASK) == '0);

endmodule

`default_nettype wire

// File: irq_csr_regs.sv
`default_nettype none

module irq_csr_regs
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [1:0]          wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic                wb_ack_o,
  output logic [31:0]         wb_dat_o,
  input  logic [NUM_IRQ-1:0]  mip_i,
  output logic [NUM_IRQ-1:0]  mie_o,
  output logic                mstatus_mie_o,
  output logic                mstatus_tw_o
);

  csr_addr_e   addr;
  logic        req;
  logic [31:0] rdata;

  assign addr = csr_addr_e'(wb_adr_i);

  // Classic cycle, one ack per request and never back to back
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // Read mux
  always_comb begin
    rdata = '0;
    case (addr)
      CSR_MIE: rdata = mie_o;
      CSR_MSTATUS: begin
        rdata[MSTATUS_MIE_BIT] = mstatus_mie_o;
        rdata[MSTATUS_TW_BIT]  = mstatus_tw_o;
      end
      CSR_MIP: rdata = mip_i;
      default: rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o      <= 1'b0;
      wb_dat_o      <= '0;
      mie_o         <= '0;
      mstatus_mie_o <= 1'b0;
      mstatus_tw_o  <= 1'b0;
    end else begin
      wb_ack_o <= req;
      if (req) begin
        wb_dat_o <= rdata;
      end
      // mip is read only, writes to it fall through
      if (req && wb_we_i) begin
        if (addr == CSR_MIE) begin
          mie_o <= wb_dat_i & VALID_IRQ_MASK;
        end
        if (addr == CSR_MSTATUS) begin
          mstatus_mie_o <= wb_dat_i[MSTATUS_MIE_BIT];
          mstatus_tw_o  <= wb_dat_i[MSTATUS_TW_BIT];
        end
      end
    end
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

  a_mie_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mie_o & ~VALID_IRQ_MASK) == '0);

endmodule

`default_nettype wire

// File: irq_pkg.sv
`default_nettype none

package irq_pkg;

  // ----------------------------------------
  // Interrupt lines
  // ----------------------------------------

  localparam int unsigned NUM_IRQ = 32;

  // Lines 31..16, 11, 7 and 3 exist on this core
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  localparam int unsigned IRQ_ID_W = 5;

  // ----------------------------------------
  // Sleep instructions
  // ----------------------------------------

  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Cycles spent in the wait states before sleep may start
  localparam int unsigned SLEEP_DELAY = 2;

  // ----------------------------------------
  // CSR layout
  // ----------------------------------------

  localparam int unsigned MSTATUS_MIE_BIT = 3;
  localparam int unsigned MSTATUS_TW_BIT  = 21;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Wishbone word addresses
  typedef enum logic [1:0] {
    CSR_MIE     = 2'd0,
    CSR_MSTATUS = 2'd1,
    CSR_MIP     = 2'd2
  } csr_addr_e;

  typedef enum logic [1:0] {
    SLP_IDLE,
    SLP_WAIT1,
    SLP_WAIT2,
    SLP_SLEEP
  } sleep_state_e;

endpackage

`default_nettype wire

// File: irq_top.sv
`default_nettype none

module irq_top
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NUM_IRQ-1:0]  irq_i,
  input  priv_lvl_e           priv_lvl_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [1:0]          wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic                wb_ack_o,
  output logic [31:0]         wb_dat_o,
  input  logic                wb_valid_i,
  input  logic [31:0]         wb_instr_i,
  input  logic                lsu_busy_i,
  input  logic                debug_req_i,
  input  logic                nmi_i,
  input  logic                wu_wfe_i,
  output logic                irq_ack_o,
  output logic [IRQ_ID_W-1:0] irq_id_o,
  output logic                core_sleep_o,
  output logic                wfi_retire_o,
  output logic                wfi_trap_o
);

  logic [NUM_IRQ-1:0]  mie;
  logic [NUM_IRQ-1:0]  mip;
  logic                mstatus_mie;
  logic                mstatus_tw;
  logic                wake_irq;
  logic                win_valid;
  logic [IRQ_ID_W-1:0] win_id;

  irq_csr_regs u_csr_regs (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_ack_o, .wb_dat_o,
    .mip_i         (mip),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie),
    .mstatus_tw_o  (mstatus_tw)
  );

  irq_arbiter u_arbiter (
    .clk_i, .rst_ni, .irq_i,
    .mie_i       (mie),
    .mip_o       (mip),
    .wake_irq_o  (wake_irq),
    .win_valid_o (win_valid),
    .win_id_o    (win_id)
  );

  irq_ack_gen u_ack_gen (
    .clk_i, .rst_ni,
    .win_valid_i   (win_valid),
    .win_id_i      (win_id),
    .mip_i         (mip),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .priv_lvl_i, .irq_ack_o, .irq_id_o
  );

  wfi_sleep_ctrl u_sleep_ctrl (
    .clk_i, .rst_ni, .wb_valid_i, .wb_instr_i, .priv_lvl_i,
    .mstatus_tw_i (mstatus_tw),
    .lsu_busy_i,
    .wake_irq_i   (wake_irq),
    .debug_req_i, .nmi_i, .wu_wfe_i,
    .core_sleep_o, .wfi_retire_o, .wfi_trap_o
  );

endmodule

`default_nettype wire

// File: project.f
irq_pkg.sv
irq_csr_regs.sv
irq_arbiter.sv
irq_ack_gen.sv
wfi_sleep_ctrl.sv
irq_top.sv
tb_clk_gen.sv
tb_irq_model.sv
tb_irq_top.sv

// File: tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset low for the first two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_irq_model.sv
`default_nettype none

module tb_irq_model
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] irq_i,
  input  priv_lvl_e   priv_lvl_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_valid_i,
  input  logic [31:0] wb_instr_i,
  input  logic        lsu_busy_i,
  input  logic        debug_req_i,
  input  logic        nmi_i,
  input  logic        wu_wfe_i,
  output logic        wb_ack_o,
  output logic        wb_rd_o,
  output logic [31:0] wb_dat_o,
  output logic        irq_ack_o,
  output logic [4:0]  irq_id_o,
  output logic        core_sleep_o,
  output logic        wfi_retire_o,
  output logic        wfi_trap_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]  mie;
  logic [31:0]  mip;
  logic         st_mie;
  logic         st_tw;
  logic         win_v;
  logic [4:0]   win;
  logic         claimed;
  logic [4:0]   claim_id;
  logic         held_wfe;
  sleep_state_e st;
  logic         req;
  logic         pend;
  logic         allow;
  logic         ack_d;
  logic         sleep_instr;
  logic         tw_blk;
  logic         wake;

  // Bit 5 of the result flags a valid pick
  function automatic logic [5:0] pick_winner(input logic [31:0] p);
    for (int i = 31; i >= 16; i--) begin
      if (p[i])
        return {1'b1, i[4:0]};
    end
    if (p[11])
      return {1'b1, 5'd11};
    if (p[3])
      return {1'b1, 5'd3};
    if (p[7])
      return {1'b1, 5'd7};
    return '0;
  endfunction

  function automatic logic [31:0] csr_value(input logic [1:0] adr);
    logic [31:0] v;
    v = '0;
    case (adr)
      CSR_MIE: v = mie;
      CSR_MSTATUS: begin
        v[MSTATUS_MIE_BIT] = st_mie;
        v[MSTATUS_TW_BIT]  = st_tw;
      end
      CSR_MIP: v = mip;
      default: v = '0;
    endcase
    return v;
  endfunction

  always_comb begin
    req         = wb_cyc_i && wb_stb_i && !wb_ack_o;
    pend        = |(mip & mie);
    allow       = (priv_lvl_i == PRIV_M) ? st_mie : pend;
    ack_d       = win_v && allow && !irq_ack_o && !(claimed && (claim_id == win));
    sleep_instr = wb_valid_i && ((wb_instr_i == WFI_INSTR) || (wb_instr_i == WFE_INSTR));
    tw_blk      = (priv_lvl_i == PRIV_U) && st_tw;
    wake        = pend || debug_req_i || nmi_i || (wu_wfe_i && held_wfe);
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {wb_ack_o, wb_rd_o, wb_dat_o, mie, mip, st_mie, st_tw} <= '0;
      {win_v, win, claimed, claim_id, irq_ack_o, irq_id_o} <= '0;
      {held_wfe, wfi_retire_o, wfi_trap_o} <= '0;
      st <= SLP_IDLE;
    end else begin
      // Wishbone slave
      wb_ack_o <= req;
      wb_rd_o  <= req && !wb_we_i;
      if (req)
        wb_dat_o <= csr_value(wb_adr_i);
      if (req && wb_we_i && (wb_adr_i == CSR_MIE))
        mie <= wb_dat_i & VALID_IRQ_MASK;
      if (req && wb_we_i && (wb_adr_i == CSR_MSTATUS)) begin
        st_mie <= wb_dat_i[MSTATUS_MIE_BIT];
        st_tw  <= wb_dat_i[MSTATUS_TW_BIT];
      end
      // Interrupt pipeline
      mip <= irq_i & VALID_IRQ_MASK;
      {win_v, win} <= pick_winner(mip & mie);
      irq_ack_o <= ack_d;
      if (ack_d) begin
        irq_id_o <= win;
        claimed  <= 1'b1;
        claim_id <= win;
      end else if (!win_v || (win != claim_id)) begin
        claimed <= 1'b0;
      end
      // Sleep state
      wfi_retire_o <= (st != SLP_IDLE) && wake;
      wfi_trap_o   <= (st == SLP_IDLE) && sleep_instr && tw_blk;
      case (st)
        SLP_IDLE: begin
          if (sleep_instr && !tw_blk) begin
            st       <= SLP_WAIT1;
            held_wfe <= (wb_instr_i == WFE_INSTR);
          end
        end
        SLP_WAIT1: st <= wake ? SLP_IDLE : SLP_WAIT2;
        SLP_WAIT2: st <= wake ? SLP_IDLE : (lsu_busy_i ? SLP_WAIT2 : SLP_SLEEP);
        default:   st <= wake ? SLP_IDLE : SLP_SLEEP;
      endcase
    end
  end

  assign core_sleep_o = (st == SLP_SLEEP);

endmodule

`default_nettype wire

// File: tb_irq_top.sv
`default_nettype none

module tb_irq_top
  import irq_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] irq;
  priv_lvl_e   priv;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat;
  logic        wb_valid;
  logic [31:0] wb_instr;
  logic        lsu_busy;
  logic        debug_req;
  logic        nmi;
  logic        wu_wfe;
  logic        wb_ack;
  logic [31:0] wb_rdata;
  logic        irq_ack;
  logic [4:0]  irq_id;
  logic        core_sleep;
  logic        wfi_retire;
  logic        wfi_trap;
  logic        m_ack;
  logic        m_rd;
  logic [31:0] m_dat;
  logic        m_irq_ack;
  logic [4:0]  m_irq_id;
  logic        m_sleep;
  logic        m_retire;
  logic        m_trap;
  integer      seed;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  irq_top uut (
    .clk_i, .rst_ni, .irq_i(irq), .priv_lvl_i(priv),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat), .wb_ack_o(wb_ack), .wb_dat_o(wb_rdata),
    .wb_valid_i(wb_valid), .wb_instr_i(wb_instr), .lsu_busy_i(lsu_busy),
    .debug_req_i(debug_req), .nmi_i(nmi), .wu_wfe_i(wu_wfe),
    .irq_ack_o(irq_ack), .irq_id_o(irq_id), .core_sleep_o(core_sleep),
    .wfi_retire_o(wfi_retire), .wfi_trap_o(wfi_trap)
  );

  tb_irq_model u_model (
    .clk_i, .rst_ni, .irq_i(irq), .priv_lvl_i(priv),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat), .wb_valid_i(wb_valid), .wb_instr_i(wb_instr),
    .lsu_busy_i(lsu_busy), .debug_req_i(debug_req), .nmi_i(nmi), .wu_wfe_i(wu_wfe),
    .wb_ack_o(m_ack), .wb_rd_o(m_rd), .wb_dat_o(m_dat), .irq_ack_o(m_irq_ack),
    .irq_id_o(m_irq_id), .core_sleep_o(m_sleep), .wfi_retire_o(m_retire),
    .wfi_trap_o(m_trap)
  );

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got,
                       exp));
  endtask

  // Outputs settle 1 ns after the rising edge
  always @(posedge clk_i) begin
    #1;
    if (rst_ni) begin
      assert (wb_ack == m_ack) else mismatch("wb_ack_o", wb_ack, m_ack);
      assert (!(m_ack && m_rd) || (wb_rdata == m_dat)) else
        mismatch("wb_dat_o read data", wb_rdata, m_dat);
      assert (irq_ack == m_irq_ack) else mismatch("irq_ack_o", irq_ack, m_irq_ack);
      assert (!m_irq_ack || (irq_id == m_irq_id)) else mismatch("irq_id_o", irq_id, m_irq_id);
      assert (core_sleep == m_sleep) else mismatch("core_sleep_o", core_sleep, m_sleep);
      assert (wfi_retire == m_retire) else mismatch("wfi_retire_o", wfi_retire, m_retire);
      assert (wfi_trap == m_trap) else mismatch("wfi_trap_o", wfi_trap, m_trap);
    end
  end

  // ----------------------------------------
  // Stimulus tasks drive on the falling edge
  // ----------------------------------------

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk_i);
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int n;
    @(negedge clk_i);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack && n < 10);
    if (!wb_ack)
      fail_run("Timeout: wb_ack_o never came for a Wishbone request");
    assert (n == 1) else mismatch("wb_ack_o latency", n, 1);
    rdata  = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // Drains the pipeline, then applies a new pattern and watches for the ack
  task automatic ack_after(input logic [31:0] pattern, input logic want_ack);
    int n;
    irq = '0;
    idle(4);
    irq = pattern;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!irq_ack && n < 8);
    if (want_ack) begin
      if (!irq_ack)
        fail_run("Timeout: irq_ack_o never rose for an enabled pending interrupt");
      assert (n == 3) else mismatch("irq_ack_o latency", n, 3);
      repeat (4) begin
        @(negedge clk_i);
        assert (!irq_ack) else mismatch("repeated irq_ack_o", irq_ack, 0);
      end
    end else begin
      assert (!irq_ack) else mismatch("irq_ack_o while gated", irq_ack, 0);
    end
  endtask

  task automatic enter_sleep(input logic [31:0] instr, input logic busy_mix);
    int n;
    @(negedge clk_i);
    wb_valid = 1'b1;
    wb_instr = instr;
    lsu_busy = busy_mix;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      wb_valid = 1'b0;
      if (busy_mix)
        lsu_busy = $random(seed) & 1;
    end while (!core_sleep && n < 40);
    if (!core_sleep)
      fail_run("Timeout: core_sleep_o never rose after WFI or WFE");
    if (!busy_mix) begin
      assert (n == 3) else mismatch("sleep entry latency", n, 3);
    end
    lsu_busy = 1'b0;
  endtask

  // Cause 0 is an enabled pending line, 1 debug, 2 NMI, 3 the WFE wake input
  task automatic wake_up(input int unsigned cause);
    int n;
    case (cause)
      0: irq = 32'h0000_0080;
      1: debug_req = 1'b1;
      2: nmi = 1'b1;
      default: wu_wfe = 1'b1;
    endcase
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (core_sleep && n < 8);
    if (core_sleep)
      fail_run("Timeout: core_sleep_o never fell after a wake cause");
    assert (wfi_retire) else mismatch("wfi_retire_o on wake", wfi_retire, 1);
    irq       = '0;
    debug_req = 1'b0;
    nmi       = 1'b0;
    wu_wfe    = 1'b0;
    idle(3);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    logic [31:0]  rd;
    logic [31:0]  en;
    logic [31:0]  line;
    logic [31:0]  instr;
    int unsigned  cause;
    int           n;
    seed = 32'hc8f7;
    {irq, wb_cyc, wb_stb, wb_we, wb_adr, wb_dat} = '0;
    {wb_valid, wb_instr, lsu_busy, debug_req, nmi, wu_wfe} = '0;
    priv = PRIV_M;
    n = 0;
    while (!rst_ni && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!rst_ni)
      fail_run("Reset was never released");

    // CSR access with random addresses and data
    repeat (24)
      wb_access($random(seed) & 1, $random(seed) & 3, $random(seed), rd);

    // mip follows the previous irq_i
    repeat (12) begin
      @(negedge clk_i);
      irq = $random(seed);
      wb_access(1'b0, CSR_MIP, '0, rd);
      assert (rd == (irq & VALID_IRQ_MASK)) else mismatch("mip read", rd, irq & VALID_IRQ_MASK);
    end

    // Priority and acknowledge in M-mode with MIE set
    wb_access(1'b1, CSR_MSTATUS, 32'h0000_0008, rd);
    repeat (10) begin
      en = $random(seed);
      en[7] = 1'b1;
      wb_access(1'b1, CSR_MIE, en, rd);
      line = $random(seed) & $random(seed);
      // Some patterns leave only the low lines to race
      if (($random(seed) & 1) != 0)
        line[31:16] = '0;
      line[7] = 1'b1;
      ack_after(line, 1'b1);
    end

    // Gating by MIE and privilege
    wb_access(1'b1, CSR_MSTATUS, '0, rd);
    ack_after(32'h0001_0080, 1'b0);
    priv = PRIV_U;
    ack_after(32'h0000_0880, 1'b1);
    wb_access(1'b1, CSR_MSTATUS, 32'h0000_0008, rd);
    ack_after(32'h8000_0088, 1'b1);
    priv = PRIV_M;
    irq  = '0;

    // Sleep entry with and without a busy load-store path
    wb_access(1'b1, CSR_MSTATUS, '0, rd);
    wb_access(1'b1, CSR_MIE, VALID_IRQ_MASK, rd);
    enter_sleep(WFI_INSTR, 1'b0);
    wake_up(1);
    enter_sleep(WFE_INSTR, 1'b1);
    wake_up(3);

    // TW in U-mode traps instead of sleeping
    priv = PRIV_U;
    wb_access(1'b1, CSR_MSTATUS, 32'h0020_0000, rd);
    @(negedge clk_i);
    wb_valid = 1'b1;
    wb_instr = WFI_INSTR;
    @(negedge clk_i);
    wb_valid = 1'b0;
    assert (wfi_trap) else mismatch("wfi_trap_o", wfi_trap, 1);
    idle(4);
    assert (!core_sleep) else mismatch("core_sleep_o after trapped WFI", core_sleep, 0);
    priv = PRIV_M;
    wb_access(1'b1, CSR_MSTATUS, '0, rd);

    // Random wake causes
    repeat (12) begin
      cause = $unsigned($random(seed)) % 4;
      instr = ((cause == 3) || (($random(seed) & 1) != 0)) ? WFE_INSTR : WFI_INSTR;
      enter_sleep(instr, $random(seed) & 1);
      wake_up(cause);
    end

    // The WFE wake input leaves a WFI asleep
    enter_sleep(WFI_INSTR, 1'b0);
    wu_wfe = 1'b1;
    idle(4);
    assert (core_sleep) else mismatch("core_sleep_o under wu_wfe_i after WFI", core_sleep, 1);
    wu_wfe = 1'b0;
    wake_up(2);

    idle(4);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: wfi_sleep_ctrl.sv
`default_nettype none

module wfi_sleep_ctrl
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_valid_i,
  input  logic [31:0] wb_instr_i,
  input  priv_lvl_e   priv_lvl_i,
  input  logic        mstatus_tw_i,
  input  logic        lsu_busy_i,
  input  logic        wake_irq_i,
  input  logic        debug_req_i,
  input  logic        nmi_i,
  input  logic        wu_wfe_i,
  output logic        core_sleep_o,
  output logic        wfi_retire_o,
  output logic        wfi_trap_o
);

  sleep_state_e state_q;
  sleep_state_e state_d;
  logic         is_wfi;
  logic         is_wfe;
  logic         tw_block;
  logic         accept;
  logic         trap_d;
  logic         wake;
  logic         is_wfe_q;

  // ----------------------------------------
  // Instruction decode in writeback
  // ----------------------------------------

  assign is_wfi   = wb_valid_i && (wb_instr_i == WFI_INSTR);
  assign is_wfe   = wb_valid_i && (wb_instr_i == WFE_INSTR);
  assign tw_block = (priv_lvl_i == PRIV_U) && mstatus_tw_i;

  assign accept = (state_q == SLP_IDLE) && (is_wfi || is_wfe) && !tw_block;
  assign trap_d = (state_q == SLP_IDLE) && (is_wfi || is_wfe) && tw_block;

  // The WFE wake input only counts for a held WFE
  assign wake = wake_irq_i || debug_req_i || nmi_i || (wu_wfe_i && is_wfe_q);

  // ----------------------------------------
  // Sleep FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLP_IDLE: begin
        if (accept) begin
          state_d = SLP_WAIT1;
        end
      end
      SLP_WAIT1: begin
        state_d = wake ? SLP_IDLE : SLP_WAIT2;
      end
      SLP_WAIT2: begin
        if (wake) begin
          state_d = SLP_IDLE;
        end else if (!lsu_busy_i) begin
          state_d = SLP_SLEEP;
        end
      end
      SLP_SLEEP: begin
        if (wake) begin
          state_d = SLP_IDLE;
        end
      end
      default: state_d = SLP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SLP_IDLE;
      is_wfe_q     <= 1'b0;
      wfi_retire_o <= 1'b0;
      wfi_trap_o   <= 1'b0;
    end else begin
      state_q      <= state_d;
      wfi_retire_o <= (state_q != SLP_IDLE) && wake;
      wfi_trap_o   <= trap_d;
      if (accept) begin
        is_wfe_q <= is_wfe;
      end
    end
  end

  assign core_sleep_o = (state_q == SLP_SLEEP);

  a_wake_exits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_sleep_o && (wake_irq_i || debug_req_i)) |=> !core_sleep_o);

  a_busy_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(core_sleep_o) |-> !$past(lsu_busy_i));

endmodule

`default_nettype wire
